// File: src/ced_img_pkg.sv
`default_nettype none

package ced_img_pkg;

  // frame geometry
  localparam int IMG_W  = 6;
  localparam int IMG_H  = 6;
  localparam int ADDR_W = 14;

  // interior pixels only, one pixel border skipped
  localparam int OUT_W      = IMG_W - 2;
  localparam int OUT_H      = IMG_H - 2;
  localparam int OUT_PIXELS = OUT_W * OUT_H;

  typedef logic [7:0]        pixel_t;
  typedef logic [ADDR_W-1:0] addr_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_READ,
    FETCH_WAIT,
    FETCH_DONE
  } fetch_state_t;

endpackage

`default_nettype wire

// File: src/ced_grad_pkg.sv
`default_nettype none

package ced_grad_pkg;

  localparam int GRAD_W    = 13;
  localparam int QUOT_W    = 29; // Q16 quotient
  localparam int FRAC_BITS = 16;
  localparam int TAPS      = 9;

  typedef logic signed [GRAD_W-1:0] grad_t;
  typedef logic        [GRAD_W-1:0] mag_t;
  typedef logic signed [QUOT_W-1:0] quot_t;

  // row-major across the 3x3 window
  localparam int GX_WEIGHT [TAPS] = '{-1, 0, 1, -2, 0, 2, -1, 0, 1};
  localparam int GY_WEIGHT [TAPS] = '{-1, -2, -1, 0, 0, 0, 1, 2, 1};

  // tan 22.5 and tan 67.5 in Q16
  localparam int TAN_LO = 27145;
  localparam int TAN_HI = 158217;

  typedef enum logic [12:0] {
    ANG_0   = 13'd0,
    ANG_45  = 13'd45,
    ANG_90  = 13'd90,
    ANG_135 = 13'd135
  } angle_t;

endpackage

`default_nettype wire

// File: src/sobel_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module sobel_fetch (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       enable,
  input  wire                       win_ready,
  output logic                      ird,
  output ced_img_pkg::addr_t        iaddr,
  output logic                      tap_valid,
  output logic [3:0]                tap_idx
);

  ced_img_pkg::fetch_state_t state;
  ced_img_pkg::addr_t        center; // address of window centre
  ced_img_pkg::addr_t        row;
  ced_img_pkg::addr_t        col;
  ced_img_pkg::addr_t        row_base;
  ced_img_pkg::addr_t        tap_addr;
  logic [3:0]                cnt;

  // row part, then column part of the tap offset
  always_comb begin
    case (cnt)
      4'd0, 4'd1, 4'd2: row_base = center - ced_img_pkg::addr_t'(ced_img_pkg::IMG_W);
      4'd3, 4'd4, 4'd5: row_base = center;
      default:          row_base = center + ced_img_pkg::addr_t'(ced_img_pkg::IMG_W);
    endcase
    case (cnt)
      4'd0, 4'd3, 4'd6: tap_addr = row_base - ced_img_pkg::addr_t'(1);
      4'd1, 4'd4, 4'd7: tap_addr = row_base;
      default:          tap_addr = row_base + ced_img_pkg::addr_t'(1);
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= ced_img_pkg::FETCH_IDLE;
      center    <= ced_img_pkg::addr_t'(ced_img_pkg::IMG_W + 1);
      row       <= '0;
      col       <= '0;
      cnt       <= '0;
      ird       <= 1'b0;
      tap_valid <= 1'b0;
    end else begin
      ird       <= 1'b0;
      tap_valid <= 1'b0;
      case (state)
        ced_img_pkg::FETCH_IDLE: begin
          if (enable) state <= ced_img_pkg::FETCH_WAIT;
        end
        ced_img_pkg::FETCH_WAIT: begin
          if (win_ready) state <= ced_img_pkg::FETCH_READ;
        end
        ced_img_pkg::FETCH_READ: begin
          ird       <= 1'b1;
          tap_valid <= 1'b1;
          if (cnt == 4'(ced_grad_pkg::TAPS - 1)) begin
            cnt   <= '0;
            state <= ced_img_pkg::FETCH_WAIT;
            if (col == ced_img_pkg::addr_t'(ced_img_pkg::OUT_W - 1)) begin
              col    <= '0;
              center <= center + ced_img_pkg::addr_t'(3); // hop over both borders
              if (row == ced_img_pkg::addr_t'(ced_img_pkg::OUT_H - 1)) begin
                state <= ced_img_pkg::FETCH_DONE;
              end else begin
                row <= row + ced_img_pkg::addr_t'(1);
              end
            end else begin
              col    <= col + ced_img_pkg::addr_t'(1);
              center <= center + ced_img_pkg::addr_t'(1);
            end
          end else begin
            cnt <= cnt + 4'd1;
          end
        end
        default: state <= ced_img_pkg::FETCH_DONE; // frame finished, wait for reset
      endcase
    end
  end

  // tap index follows the read it belongs to
  always_ff @(posedge clk) begin
    if (state == ced_img_pkg::FETCH_READ) begin
      iaddr   <= tap_addr;
      tap_idx <= cnt;
    end
  end

  a_iaddr_in_frame: assert property (@(posedge clk) disable iff (rst)
    ird |-> iaddr < ced_img_pkg::addr_t'(ced_img_pkg::IMG_W * ced_img_pkg::IMG_H))
    else $error("image read outside the frame at %0d", iaddr);

endmodule

`default_nettype wire

// File: src/sobel_conv.sv
`timescale 1ns/10ps
`default_nettype none

module sobel_conv (
  input  wire                       clk,
  input  wire                       rst,
  input  wire ced_img_pkg::pixel_t  idata,
  input  wire                       tap_valid,
  input  wire [3:0]                 tap_idx,
  input  wire                       grad_ready,
  output logic                      win_ready,
  output logic                      grad_valid,
  output ced_grad_pkg::grad_t       gx,
  output ced_grad_pkg::grad_t       gy
);

  ced_grad_pkg::grad_t pix;
  ced_grad_pkg::grad_t s1_tx;
  ced_grad_pkg::grad_t s1_ty;
  logic [3:0]          s1_idx;
  logic                s1_valid;

  assign pix = ced_grad_pkg::grad_t'(idata);

  // nothing pending and no window still in the pipe
  assign win_ready = ~(grad_valid | s1_valid | tap_valid);

  // weighted products, one tap per cycle
  always_ff @(posedge clk) begin
    s1_idx <= tap_idx;
    s1_tx  <= pix * ced_grad_pkg::grad_t'(ced_grad_pkg::GX_WEIGHT[tap_idx]);
    s1_ty  <= pix * ced_grad_pkg::grad_t'(ced_grad_pkg::GY_WEIGHT[tap_idx]);
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      if (s1_idx == 4'd0) begin
        gx <= s1_tx; // new window
        gy <= s1_ty;
      end else begin
        gx <= gx + s1_tx;
        gy <= gy + s1_ty;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid   <= 1'b0;
      grad_valid <= 1'b0;
    end else begin
      s1_valid <= tap_valid;
      if (s1_valid && s1_idx == 4'(ced_grad_pkg::TAPS - 1)) begin
        grad_valid <= 1'b1;
      end else if (grad_ready) begin
        grad_valid <= 1'b0;
      end
    end
  end

  a_no_tap_while_pending: assert property (@(posedge clk) disable iff (rst)
    tap_valid |-> !grad_valid)
    else $error("pixel arrived while a gradient was still pending");

endmodule

`default_nettype wire

// File: src/grad_divider.sv
`timescale 1ns/10ps
`default_nettype none

module grad_divider (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       div_start,
  input  wire ced_grad_pkg::quot_t  dividend,
  input  wire ced_grad_pkg::grad_t  divisor,
  output logic                      div_done,
  output ced_grad_pkg::quot_t       quot
);

  logic [ced_grad_pkg::QUOT_W-1:0] shreg; // dividend bits out, quotient bits in
  logic [ced_grad_pkg::GRAD_W-1:0] rem;
  logic [ced_grad_pkg::GRAD_W-1:0] dvs;
  logic [ced_grad_pkg::GRAD_W:0]   trial;
  logic [ced_grad_pkg::GRAD_W:0]   diff;
  logic [4:0]                      iter;
  logic                            neg;
  logic                            busy;

  assign trial = {rem, shreg[ced_grad_pkg::QUOT_W-1]};
  assign diff  = trial - {1'b0, dvs};
  assign quot  = neg ? -shreg : shreg;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy     <= 1'b0;
      iter     <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        busy <= 1'b1;
        iter <= '0;
      end else if (busy) begin
        iter <= iter + 5'd1;
        if (iter == 5'(ced_grad_pkg::QUOT_W - 1)) begin
          busy     <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_start) begin
      shreg <= dividend[ced_grad_pkg::QUOT_W-1] ? -dividend : dividend;
      dvs   <= divisor[ced_grad_pkg::GRAD_W-1] ? -divisor : divisor;
      rem   <= '0;
      neg   <= dividend[ced_grad_pkg::QUOT_W-1] ^ divisor[ced_grad_pkg::GRAD_W-1];
    end else if (busy) begin
      if (trial >= {1'b0, dvs}) begin
        rem   <= diff[ced_grad_pkg::GRAD_W-1:0];
        shreg <= {shreg[ced_grad_pkg::QUOT_W-2:0], 1'b1};
      end else begin
        rem   <= trial[ced_grad_pkg::GRAD_W-1:0]; // restore
        shreg <= {shreg[ced_grad_pkg::QUOT_W-2:0], 1'b0};
      end
    end
  end

  a_nonzero_divisor: assert property (@(posedge clk) disable iff (rst)
    div_start |-> divisor != '0)
    else $error("divider started with gx of zero");

endmodule

`default_nettype wire

// File: src/edge_direction.sv
`timescale 1ns/10ps
`default_nettype none

module edge_direction (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       grad_valid,
  input  wire ced_grad_pkg::grad_t  gx,
  input  wire ced_grad_pkg::grad_t  gy,
  output logic                      grad_ready,
  output logic                      res_valid,
  output ced_grad_pkg::mag_t        mag,
  output ced_grad_pkg::angle_t      ang
);

  ced_grad_pkg::grad_t  gx_r;
  ced_grad_pkg::grad_t  gy_r;
  ced_grad_pkg::mag_t   abs_gx;
  ced_grad_pkg::mag_t   abs_gy;
  ced_grad_pkg::quot_t  dividend;
  ced_grad_pkg::quot_t  quot;
  ced_grad_pkg::angle_t q_ang;
  logic                 take;
  logic                 busy;
  logic                 div_start;
  logic                 div_done;

  assign grad_ready = ~busy;
  assign take       = grad_valid & grad_ready;
  assign abs_gx     = gx[ced_grad_pkg::GRAD_W-1] ? -gx : gx;
  assign abs_gy     = gy[ced_grad_pkg::GRAD_W-1] ? -gy : gy;
  assign dividend   = ced_grad_pkg::quot_t'(gy_r) <<< ced_grad_pkg::FRAC_BITS;

  grad_divider i_grad_divider (
    .clk       (clk),
    .rst       (rst),
    .div_start (div_start),
    .dividend  (dividend),
    .divisor   (gx_r),
    .div_done  (div_done),
    .quot      (quot)
  );

  // gy/gx in Q16 against tan 22.5 and tan 67.5
  always_comb begin
    if (quot < ced_grad_pkg::TAN_LO && quot > -ced_grad_pkg::TAN_LO) begin
      q_ang = ced_grad_pkg::ANG_0;
    end else if (quot >= ced_grad_pkg::TAN_LO && quot < ced_grad_pkg::TAN_HI) begin
      q_ang = ced_grad_pkg::ANG_45;
    end else if (quot >= ced_grad_pkg::TAN_HI || quot <= -ced_grad_pkg::TAN_HI) begin
      q_ang = ced_grad_pkg::ANG_90;
    end else begin
      q_ang = ced_grad_pkg::ANG_135;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy      <= 1'b0;
      div_start <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      div_start <= take && gx != '0;
      res_valid <= (take && gx == '0) || div_done;
      if (take && gx != '0) begin
        busy <= 1'b1;
      end else if (div_done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      gx_r <= gx;
      gy_r <= gy;
      mag  <= abs_gx + abs_gy;
      // only kept when gx is zero, else replaced by the divider result
      ang  <= (gy == '0) ? ced_grad_pkg::ANG_0 : ced_grad_pkg::ANG_90;
    end else if (div_done) begin
      ang <= q_ang;
    end
  end

endmodule

`default_nettype wire

// File: src/result_writer.sv
`timescale 1ns/10ps
`default_nettype none

module result_writer (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        res_valid,
  input  wire ced_grad_pkg::mag_t    mag,
  input  wire ced_grad_pkg::angle_t  ang,
  output logic                       cwr_mag,
  output ced_img_pkg::addr_t         caddr_mag,
  output ced_grad_pkg::mag_t         cdata_mag,
  output logic                       cwr_ang,
  output ced_img_pkg::addr_t         caddr_ang,
  output ced_grad_pkg::angle_t       cdata_ang,
  output logic                       done
);

  ced_img_pkg::addr_t wr_cnt; // next result address
  ced_img_pkg::addr_t wr_addr;
  logic               wr;

  // both memories written in lockstep
  assign cwr_mag   = wr;
  assign cwr_ang   = wr;
  assign caddr_mag = wr_addr;
  assign caddr_ang = wr_addr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr     <= 1'b0;
      wr_cnt <= '0;
      done   <= 1'b0;
    end else begin
      wr <= res_valid;
      if (res_valid) begin
        wr_cnt <= wr_cnt + ced_img_pkg::addr_t'(1);
        if (wr_cnt == ced_img_pkg::addr_t'(ced_img_pkg::OUT_PIXELS - 1)) done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid) begin
      wr_addr   <= wr_cnt;
      cdata_mag <= mag;
      cdata_ang <= ang;
    end
  end

  a_no_result_after_done: assert property (@(posedge clk) disable iff (rst)
    done |-> !res_valid)
    else $error("result arrived after the frame completed");

endmodule

`default_nettype wire

// File: src/canny_grad.sv
`timescale 1ns/10ps
`default_nettype none

module canny_grad (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        enable,
  input  wire ced_img_pkg::pixel_t   idata,
  output logic                       ird,
  output ced_img_pkg::addr_t         iaddr,
  output logic                       cwr_mag,
  output ced_img_pkg::addr_t         caddr_mag,
  output ced_grad_pkg::mag_t         cdata_mag,
  output logic                       cwr_ang,
  output ced_img_pkg::addr_t         caddr_ang,
  output ced_grad_pkg::angle_t       cdata_ang,
  output logic                       done
);

  logic                 win_ready;
  logic                 tap_valid;
  logic [3:0]           tap_idx;
  logic                 grad_valid;
  logic                 grad_ready;
  ced_grad_pkg::grad_t  gx;
  ced_grad_pkg::grad_t  gy;
  logic                 res_valid;
  ced_grad_pkg::mag_t   mag;
  ced_grad_pkg::angle_t ang;

  sobel_fetch i_sobel_fetch (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .win_ready (win_ready),
    .ird       (ird),
    .iaddr     (iaddr),
    .tap_valid (tap_valid),
    .tap_idx   (tap_idx)
  );

  sobel_conv i_sobel_conv (
    .clk        (clk),
    .rst        (rst),
    .idata      (idata),
    .tap_valid  (tap_valid),
    .tap_idx    (tap_idx),
    .grad_ready (grad_ready),
    .win_ready  (win_ready),
    .grad_valid (grad_valid),
    .gx         (gx),
    .gy         (gy)
  );

  edge_direction i_edge_direction (
    .clk        (clk),
    .rst        (rst),
    .grad_valid (grad_valid),
    .gx         (gx),
    .gy         (gy),
    .grad_ready (grad_ready),
    .res_valid  (res_valid),
    .mag        (mag),
    .ang        (ang)
  );

  result_writer i_result_writer (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .mag       (mag),
    .ang       (ang),
    .cwr_mag   (cwr_mag),
    .caddr_mag (caddr_mag),
    .cdata_mag (cdata_mag),
    .cwr_ang   (cwr_ang),
    .caddr_ang (caddr_ang),
    .cdata_ang (cdata_ang),
    .done      (done)
  );

endmodule

`default_nettype wire

// File: testbench/tb_canny_grad.sv
`timescale 1ns/10ps
`default_nettype none

module tb_canny_grad;

  localparam int HALF_PERIOD = 20; // 40 ns clock
  localparam int NUM_TESTS   = 3;
  localparam int TAIL_CYCLES = 20;
  localparam int PIXELS      = ced_img_pkg::IMG_W * ced_img_pkg::IMG_H;
  localparam int OUT_PIXELS  = ced_img_pkg::OUT_PIXELS;
  localparam int TEST_CYCLES = OUT_PIXELS * 100 + 60; // 100 per pixel plus reset and tail

  logic                 clk;
  logic                 rst;
  logic                 enable;
  ced_img_pkg::pixel_t  idata = '0;
  logic                 ird;
  ced_img_pkg::addr_t   iaddr;
  logic                 cwr_mag;
  ced_img_pkg::addr_t   caddr_mag;
  ced_grad_pkg::mag_t   cdata_mag;
  logic                 cwr_ang;
  ced_img_pkg::addr_t   caddr_ang;
  ced_grad_pkg::angle_t cdata_ang;
  logic                 done;

  ced_img_pkg::pixel_t  img [PIXELS];
  ced_grad_pkg::mag_t   exp_mag [OUT_PIXELS];
  ced_grad_pkg::angle_t exp_ang [OUT_PIXELS];
  string                test_name;
  int                   fd;
  int                   wr_count;
  int                   rd_count;
  logic                 done_seen;

  canny_grad i_canny_grad (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .idata     (idata),
    .ird       (ird),
    .iaddr     (iaddr),
    .cwr_mag   (cwr_mag),
    .caddr_mag (caddr_mag),
    .cdata_mag (cdata_mag),
    .cwr_ang   (cwr_ang),
    .caddr_ang (caddr_ang),
    .cdata_ang (cdata_ang),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // image memory answers for the next rising edge
  always @(negedge clk) begin
    if (ird) idata <= img[int'(iaddr)];
  end

  task automatic stop_run(string reason);
    $display("%s (test %s)", reason, test_name);
    $display("test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_mag(string what, ced_grad_pkg::mag_t expected,
                           ced_grad_pkg::mag_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %0d, got %0d", test_name, what, expected, actual);
      $display("test failed");
      $fatal(1, "magnitude mismatch");
    end
  endtask

  task automatic check_ang(string what, ced_grad_pkg::angle_t expected,
                           ced_grad_pkg::angle_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %0d, got %0d", test_name, what, expected, actual);
      $display("test failed");
      $fatal(1, "angle mismatch");
    end
  endtask

  task automatic check_addr(string what, ced_img_pkg::addr_t expected,
                            ced_img_pkg::addr_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %0d, got %0d", test_name, what, expected, actual);
      $display("test failed");
      $fatal(1, "address mismatch");
    end
  endtask

  // window centres in raster order, taps row-major around each
  function automatic ced_img_pkg::addr_t window_addr(int n);
    int win;
    int tap;
    int center;
    win    = n / ced_grad_pkg::TAPS;
    tap    = n % ced_grad_pkg::TAPS;
    center = (win / ced_img_pkg::OUT_W + 1) * ced_img_pkg::IMG_W
             + win % ced_img_pkg::OUT_W + 1;
    return ced_img_pkg::addr_t'(center + (tap / 3 - 1) * ced_img_pkg::IMG_W + tap % 3 - 1);
  endfunction

  // next token of the data file
  task automatic read_word(output string word);
    string rest;
    int    code;
    word = "";
    while (word == "") begin
      code = $fscanf(fd, "%s", word);
      if (code != 1) begin
        stop_run("data file ended before all tests were read");
      end else if (word[0] == "#") begin
        code = $fgets(rest, fd); // rest of a comment line
        word = "";
      end
    end
  endtask

  task automatic read_hex(output int value);
    string word;
    read_word(word);
    if ($sscanf(word, "%h", value) != 1) stop_run("bad hex value in data file");
  endtask

  task automatic read_dec(output int value);
    string word;
    read_word(word);
    if ($sscanf(word, "%d", value) != 1) stop_run("bad decimal value in data file");
  endtask

  task automatic load_test();
    int value;
    int ang_value;
    read_word(test_name);
    for (int i = 0; i < PIXELS; i++) begin
      read_hex(value);
      img[i] = ced_img_pkg::pixel_t'(value);
    end
    for (int i = 0; i < OUT_PIXELS; i++) begin
      read_hex(value);
      read_dec(ang_value);
      exp_mag[i] = ced_grad_pkg::mag_t'(value);
      exp_ang[i] = ced_grad_pkg::angle_t'(ang_value);
    end
  endtask

  task automatic check_idle();
    if (ird !== 1'b0 || cwr_mag !== 1'b0 || cwr_ang !== 1'b0 || done !== 1'b0)
      stop_run("outputs not idle after reset");
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst    = 1'b1;
    enable = 1'b0;
    repeat (3) @(negedge clk);
    check_idle();
    rst = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle(); // still idle without enable
    end
  endtask

  // outputs settled since the last rising edge
  task automatic watch_cycle();
    string what;
    if (cwr_mag !== cwr_ang) stop_run("magnitude and angle write strobes differ");
    if (done === 1'b1 && ird !== 1'b0) stop_run("image read after done");
    if (ird === 1'b1) begin
      if (rd_count >= ced_grad_pkg::TAPS * OUT_PIXELS) begin
        stop_run("image read after the last window");
      end else begin
        check_addr($sformatf("read %0d image address", rd_count), window_addr(rd_count),
                   iaddr);
        rd_count++;
      end
    end
    if (cwr_mag === 1'b1) begin
      if (wr_count >= OUT_PIXELS) begin
        stop_run("write after the last interior pixel");
      end else begin
        what = $sformatf("pixel %0d", wr_count);
        check_addr({what, " magnitude address"}, ced_img_pkg::addr_t'(wr_count), caddr_mag);
        check_addr({what, " angle address"}, ced_img_pkg::addr_t'(wr_count), caddr_ang);
        check_mag({what, " magnitude"}, exp_mag[wr_count], cdata_mag);
        check_ang({what, " angle"}, exp_ang[wr_count], cdata_ang);
        if ((wr_count == OUT_PIXELS - 1) != (done === 1'b1))
          stop_run("done not raised together with the last write");
        wr_count++;
      end
    end
    if (done === 1'b1) begin
      if (wr_count != OUT_PIXELS) stop_run("done raised before all pixels were written");
      done_seen = 1'b1;
    end
  endtask

  task automatic run_test();
    load_test();
    apply_reset();
    wr_count  = 0;
    rd_count  = 0;
    done_seen = 1'b0;
    enable    = 1'b1;
    @(negedge clk);
    watch_cycle();
    enable = 1'b0;
    while (!done_seen) begin
      @(negedge clk);
      watch_cycle();
    end
    repeat (TAIL_CYCLES) begin
      @(negedge clk);
      watch_cycle(); // no reads or writes once done
      if (done !== 1'b1) stop_run("done dropped before the next reset");
    end
    $display("%s: %0d pixels checked", test_name, wr_count);
  endtask

  initial begin
    rst    = 1'b1;
    enable = 1'b0;
    fd     = $fopen("testbench/canny_grad_tests.txt", "r");
    if (fd == 0) stop_run("cannot open testbench/canny_grad_tests.txt");
    for (int t = 0; t < NUM_TESTS; t++) run_test();
    $fclose(fd);
    $display("test passed");
    $finish;
  end

  // watchdog sized from the length of all tests
  initial begin
    repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
    $display("done never came within %0d cycles for %0d tests",
             NUM_TESTS * TEST_CYCLES, NUM_TESTS);
    $display("test failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

// File: canny_grad.f
src/ced_img_pkg.sv
src/ced_grad_pkg.sv
src/sobel_fetch.sv
src/sobel_conv.sv
src/grad_divider.sv
src/edge_direction.sv
src/result_writer.sv
src/canny_grad.sv
testbench/tb_canny_grad.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the gradient testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_canny_grad \
  -f canny_grad.f \
  -Mdir obj_dir -o sim_canny_grad
if [ $? -ne 0 ]; then
  echo "verilator build did not succeed"
  exit 1
fi

./obj_dir/sim_canny_grad
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi
exit 0

// File: testbench/canny_grad_tests.txt
# per test: name, then 6 rows of 6 hex pixels
# then 4 rows of 4 pairs: hex magnitude and decimal angle, raster order
ramp
00 04 0C 18 28 3C
06 0A 12 1E 2E 42
0C 10 18 24 34 48
12 16 1E 2A 3A 4E
18 1C 24 30 40 54
1E 22 2A 36 46 5A
060 45 080 45 0A0 45 0C0 0
060 45 080 45 0A0 45 0C0 0
060 45 080 45 0A0 45 0C0 0
060 45 080 45 0A0 45 0C0 0
edges
00 00 00 00 00 00
00 00 00 00 00 64
00 00 00 00 64 64
64 64 00 64 64 64
64 64 00 00 00 00
64 64 00 00 00 00
000 0 000 0 0C8 45 258 45
190 90 0C8 90 258 45 258 45
258 135 0C8 135 190 0 190 90
190 0 190 0 190 90 190 90
repeat
00 00 00 00 00 00
00 00 00 00 00 64
00 00 00 00 64 64
64 64 00 64 64 64
64 64 00 00 00 00
64 64 00 00 00 00
000 0 000 0 0C8 45 258 45
190 90 0C8 90 258 45 258 45
258 135 0C8 135 190 0 190 90
190 0 190 0 190 90 190 90
